// ==== hw/hazard_settings.svh ====
`ifndef HAZARD_SETTINGS_SVH
`define HAZARD_SETTINGS_SVH

// datapath word and register index widths
`define DATA_W 32
`define REG_AW 5

// bypass source codes for the execute operands
`define FWD_NONE 2'd0 // register file value
`define FWD_MEM  2'd1 // result held in the memory stage
`define FWD_WB   2'd2 // result held in the writeback stage

`endif

// ==== hw/hazardPkg.sv ====
`include "hazard_settings.svh"

package hazardPkg;

    // R-type layout, register to register ops
    typedef struct packed {
        logic [5:0]         op;    // zero for the whole R group
        logic [`REG_AW-1:0] rs;    // first source
        logic [`REG_AW-1:0] rt;    // second source
        logic [`REG_AW-1:0] rd;    // destination
        logic [4:0]         shamt;
        logic [5:0]         funct; // picks the ALU op, not modelled
    } rFields_t;

    // I-type layout, immediate ops, loads, stores and branches
    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;  // destination for loads and ALU immediates
        logic [15:0]        imm;
    } iFields_t;

    // one fetched word seen through either layout
    // op and rs sit at the same bits in both views
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_t;

endpackage

// ==== hw/stageBus.sv ====
`timescale 1ns/1ns
`include "hazard_settings.svh"

interface stageBus;

    logic [`REG_AW-1:0] rsE;       // execute stage sources
    logic [`REG_AW-1:0] rtE;
    logic               regWriteM; // memory entry valid and writing
    logic [`REG_AW-1:0] destM;
    logic               regWriteW; // writeback entry valid and writing
    logic [`REG_AW-1:0] destW;
    logic               validE;    // execute holds a live entry

    // tracker side, publishes the stage snapshot
    modport track (
        output rsE, rtE, regWriteM, destM, regWriteW, destW, validE
    );

    // bypass side
    modport fwd (
        input rsE, rtE, regWriteM, destM, regWriteW, destW, validE
    );

endinterface

// ==== hw/hazardCtl.sv ====
`timescale 1ns/1ns

interface hazardCtl;

    // hold keeps a stage register as it is
    logic holdF;
    logic holdD;
    logic holdE;
    logic holdM;
    logic holdW;

    // flush turns a stage register into a bubble, wins over hold
    logic flushD;
    logic flushE;
    logic flushM;

    modport drive (
        output holdF, holdD, holdE, holdM, holdW, flushD, flushE, flushM
    );

    modport apply (
        input holdF, holdD, holdE, holdM, holdW, flushD, flushE, flushM
    );

endinterface

// ==== hw/forwardUnit.sv ====
`timescale 1ns/1ns
`include "hazard_settings.svh"

module forwardUnit (
    stageBus.fwd       sb,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB
);

    // bypass choice for one execute source
    // the younger memory result wins over writeback
    function automatic logic [1:0] pickSrc(input logic [`REG_AW-1:0] src);
        logic [1:0] sel;
        sel = `FWD_NONE;
        if (sb.validE && src != '0) begin // r0 is hardwired, never bypassed
            if (sb.regWriteM && src == sb.destM)
                sel = `FWD_MEM;
            else if (sb.regWriteW && src == sb.destW)
                sel = `FWD_WB;
        end
        return sel;
    endfunction

    // same guard on both operands
    assign fwdA = pickSrc(sb.rsE);
    assign fwdB = pickSrc(sb.rtE);

endmodule

// ==== hw/stallFlushUnit.sv ====
`timescale 1ns/1ns

module stallFlushUnit (
    input  logic     clk,
    input  logic     reset,
    input  logic     iCacheStall,
    input  logic     dCacheStall,
    input  logic     divStall,     // divide busy in execute
    input  logic     predFail,     // wrong branch prediction
    input  logic     jumpConflict, // jump target not ready
    input  logic     exception,
    hazardCtl.drive  hc,
    output logic     stallWindow
);

    logic cacheStall;
    logic longStall;
    logic longStallQ; // longStall one cycle late

    assign cacheStall = iCacheStall | dCacheStall;
    assign longStall  = cacheStall | divStall;

    always_ff @(posedge clk) begin
        if (reset) begin
            longStallQ <= 1'b0;
        end else begin
            longStallQ <= longStall;
        end
    end

    // covers the stall and the cycle right after it
    assign stallWindow = longStall | longStallQ;

    // front end freezes on any long stall
    // an exception still lets fetch move to the handler
    assign hc.holdF = longStall & ~exception;
    assign hc.holdD = longStall;
    assign hc.holdE = longStall;

    // only a cache miss freezes the back end
    assign hc.holdM = cacheStall; // divide lets memory and writeback drain
    assign hc.holdW = cacheStall;

    // redirects only land once the pipe is moving
    assign hc.flushD = exception | ((predFail | jumpConflict) & ~longStall);
    assign hc.flushE = exception | (predFail & ~longStall);

    // bubble into M behind a divide that sits in E
    assign hc.flushM = exception | (divStall & ~cacheStall);

endmodule

// ==== hw/pipeTrack.sv ====
`timescale 1ns/1ns
`include "hazard_settings.svh"

module pipeTrack
    import hazardPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               issueValid,
    input  instrWord_t         issueInstr,
    input  logic [`DATA_W-1:0] issueResult, // precomputed result of the op
    hazardCtl.apply            hc,
    stageBus.track             sb,
    input  logic [1:0]         fwdA,
    input  logic [1:0]         fwdB,
    output logic [`DATA_W-1:0] operandA,
    output logic [`DATA_W-1:0] operandB,
    output logic               commitValid,
    output logic [`REG_AW-1:0] commitDest,
    output logic [`DATA_W-1:0] commitData
);

    localparam int NREGS = 1 << `REG_AW;

    logic [`DATA_W-1:0] regFile [0:NREGS-1];

    // decoded view of the word at the issue port
    logic [`REG_AW-1:0] issueDest;
    logic               issueWe;

    // stage entries
    logic               validD, validE, validM, validW;
    logic [`REG_AW-1:0] rsD, rtD, rsE, rtE;
    logic [`REG_AW-1:0] destD, destE, destM, destW;
    logic               weD, weE, weM, weW;
    logic [`DATA_W-1:0] resultD, resultE, resultM, resultW;

    always_comb begin
        // R group writes rd, everything else writes rt
        if (issueInstr.i.op == '0)
            issueDest = issueInstr.r.rd;
        else
            issueDest = issueInstr.i.rt;
        // branches (op 4..7) and stores (op 0x28..0x2f) retire without a write
        issueWe = !(issueInstr.r.op[5:2] == 4'b0001 || issueInstr.r.op[5:3] == 3'b101);
    end

    // valid bits, flush first, then hold, else shift
    // a held stage hands a bubble to the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
            validE <= 1'b0;
            validM <= 1'b0;
            validW <= 1'b0;
        end else begin
            if (hc.flushD)
                validD <= 1'b0;
            else if (!hc.holdD)
                validD <= issueValid; // issue dropped while D is held
            if (hc.flushE)
                validE <= 1'b0;
            else if (!hc.holdE)
                validE <= validD & ~hc.holdD;
            if (hc.flushM)
                validM <= 1'b0;
            else if (!hc.holdM)
                validM <= validE & ~hc.holdE;
            if (!hc.holdW)
                validW <= validM & ~hc.holdM; // W is never flushed
        end
    end

    // payload just follows the holds, valid says whether it counts
    always_ff @(posedge clk) begin
        if (!hc.holdD) begin
            rsD     <= issueInstr.r.rs;
            rtD     <= issueInstr.i.rt; // same bits as r.rt
            destD   <= issueDest;
            weD     <= issueWe;
            resultD <= issueResult;
        end
        if (!hc.holdE) begin
            rsE     <= rsD;
            rtE     <= rtD;
            destE   <= destD;
            weE     <= weD;
            resultE <= resultD;
        end
        if (!hc.holdM) begin
            destM   <= destE;
            weM     <= weE;
            resultM <= resultE;
        end
        if (!hc.holdW) begin
            destW   <= destM;
            weW     <= weM;
            resultW <= resultM;
        end
    end

    // snapshot for the bypass logic
    assign sb.rsE       = rsE;
    assign sb.rtE       = rtE;
    assign sb.validE    = validE;
    assign sb.regWriteM = validM & weM;
    assign sb.destM     = destM;
    assign sb.regWriteW = validW & weW;
    assign sb.destW     = destW;

    // execute operand, bypassed result or register file word
    function automatic logic [`DATA_W-1:0] pickOperand(
        input logic [1:0]         sel,
        input logic [`DATA_W-1:0] rfWord
    );
        logic [`DATA_W-1:0] val;
        case (sel)
            `FWD_MEM: val = resultM;
            `FWD_WB:  val = resultW;
            default:  val = rfWord;
        endcase
        return val;
    endfunction

    assign operandA = pickOperand(fwdA, regFile[rsE]);
    assign operandB = pickOperand(fwdB, regFile[rtE]);

    // retire in the cycle W lets go of its entry
    assign commitValid = validW & weW & ~hc.holdW;
    assign commitDest  = destW;
    assign commitData  = resultW;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++)
                regFile[i] <= '0;
        end else if (commitValid && destW != '0) begin // r0 stays zero
            regFile[destW] <= resultW;
        end
    end

endmodule

// ==== hw/hazardTop.sv ====
`timescale 1ns/1ns
`include "hazard_settings.svh"

module hazardTop
    import hazardPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               issueValid,
    input  instrWord_t         issueInstr,
    input  logic [`DATA_W-1:0] issueResult,
    input  logic               iCacheStall,
    input  logic               dCacheStall,
    input  logic               divStall,
    input  logic               predFail,
    input  logic               jumpConflict,
    input  logic               exception,
    output logic               holdF,
    output logic               holdD,
    output logic               holdE,
    output logic               holdM,
    output logic               holdW,
    output logic               flushD,
    output logic               flushE,
    output logic               flushM,
    output logic               stallWindow,
    output logic [1:0]         fwdA,
    output logic [1:0]         fwdB,
    output logic [`DATA_W-1:0] operandA,
    output logic [`DATA_W-1:0] operandB,
    output logic               commitValid,
    output logic [`REG_AW-1:0] commitDest,
    output logic [`DATA_W-1:0] commitData
);

    stageBus  sbus (); // stage snapshot, tracker to bypass logic
    hazardCtl hctl (); // holds and flushes, controller to tracker

    forwardUnit fwdUnit (
        .sb   (sbus.fwd),
        .fwdA (fwdA),
        .fwdB (fwdB)
    );

    stallFlushUnit sfUnit (
        .clk          (clk),
        .reset        (reset),
        .iCacheStall  (iCacheStall),
        .dCacheStall  (dCacheStall),
        .divStall     (divStall),
        .predFail     (predFail),
        .jumpConflict (jumpConflict),
        .exception    (exception),
        .hc           (hctl.drive),
        .stallWindow  (stallWindow)
    );

    pipeTrack tracker (
        .clk         (clk),
        .reset       (reset),
        .issueValid  (issueValid),
        .issueInstr  (issueInstr),
        .issueResult (issueResult),
        .hc          (hctl.apply),
        .sb          (sbus.track),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .operandA    (operandA),
        .operandB    (operandB),
        .commitValid (commitValid),
        .commitDest  (commitDest),
        .commitData  (commitData)
    );

    // control decisions also leave the top for observation
    assign holdF  = hctl.holdF;
    assign holdD  = hctl.holdD;
    assign holdE  = hctl.holdE;
    assign holdM  = hctl.holdM;
    assign holdW  = hctl.holdW;
    assign flushD = hctl.flushD;
    assign flushE = hctl.flushE;
    assign flushM = hctl.flushM;

endmodule

// ==== test/hazard_properties.sv ====
`timescale 1ns/1ns

module hazardProps (
    input logic clk,
    input logic reset,
    input logic iCacheStall,
    input logic dCacheStall,
    input logic divStall,
    input logic holdF,
    input logic holdD,
    input logic holdE,
    input logic holdM,
    input logic holdW,
    input logic flushD,
    input logic flushE,
    input logic flushM,
    input logic stallWindow
);

    logic longStall;

    assign longStall = iCacheStall | dCacheStall | divStall;

    // inputs are quiet while reset is applied, so the control word must be too
    quietInReset: assert property (@(posedge clk)
        reset |-> !(holdF || holdD || holdE || holdM || holdW || flushD || flushE || flushM))
        else $error("hold or flush active during reset");

    // any squash of E also squashes the younger D entry
    flushNesting: assert property (@(posedge clk) disable iff (reset) flushE |-> flushD)
        else $error("flushE raised without flushD");

    windowTail: assert property (@(posedge clk) disable iff (reset) longStall |=> stallWindow)
        else $error("stallWindow low in the cycle after a long stall");

endmodule

bind hazardTop hazardProps props (.*);

// ==== test/tbHazard.sv ====
`timescale 1ns/1ns
`include "hazard_settings.svh"

module tbHazard
    import hazardPkg::*;
();

    localparam int NRESET  = 10;
    localparam int NCYCLES = 2000;
    localparam int TIMEOUT = 2 * NCYCLES; // hung run limit

    logic               clk;
    logic               reset;
    logic               issueValid;
    instrWord_t         issueInstr;
    logic [`DATA_W-1:0] issueResult;
    logic               iCacheStall, dCacheStall, divStall;
    logic               predFail, jumpConflict, exception;
    logic               holdF, holdD, holdE, holdM, holdW;
    logic               flushD, flushE, flushM;
    logic               stallWindow;
    logic [1:0]         fwdA, fwdB;
    logic [`DATA_W-1:0] operandA, operandB;
    logic               commitValid;
    logic [`REG_AW-1:0] commitDest;
    logic [`DATA_W-1:0] commitData;

    integer     seed;
    int         cycles = 0;
    logic [7:0] ctl;

    // cycle model, index 0..3 is D, E, M, W
    logic               mValid [0:3];
    logic [`REG_AW-1:0] mDest  [0:3];
    logic               mWe    [0:3];
    logic [`DATA_W-1:0] mRes   [0:3];
    logic [`REG_AW-1:0] mRs    [0:1]; // sources only needed up to E
    logic [`REG_AW-1:0] mRt    [0:1];
    logic [`DATA_W-1:0] mRf    [0:31];
    logic               mLongQ;       // long stall seen last cycle

    hazardTop uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
            failRun($sformatf("run timed out after %0d cycles without finishing", cycles));
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic checkCtl(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkFwd(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic checkWord(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkReg(input string name, input logic [`REG_AW-1:0] got,
                            input logic [`REG_AW-1:0] exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            failRun($sformatf("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    // {holdF, holdD, holdE, holdM, holdW, flushD, flushE, flushM}
    function automatic logic [7:0] ctlRule();
        logic cache;
        logic lng;
        cache = iCacheStall | dCacheStall;
        lng   = cache | divStall;
        return {lng & ~exception, lng, lng, cache, cache,
                exception | ((predFail | jumpConflict) & ~lng),
                exception | (predFail & ~lng),
                exception | (divStall & ~cache)}; // bubble behind a held divide
    endfunction

    // branches 4..7 and stores 0x28..0x2f leave the register file alone
    function automatic logic writesReg(input logic [5:0] op);
        return !((op >= 6'h04 && op <= 6'h07) || (op >= 6'h28 && op <= 6'h2f));
    endfunction

    function automatic logic [1:0] bypassSel(input logic [`REG_AW-1:0] src);
        if (!mValid[1] || src == '0)
            return `FWD_NONE; // r0 never forwards
        if (mValid[2] && mWe[2] && mDest[2] == src)
            return `FWD_MEM;  // youngest producer first
        if (mValid[3] && mWe[3] && mDest[3] == src)
            return `FWD_WB;
        return `FWD_NONE;
    endfunction

    function automatic logic [`DATA_W-1:0] operandValue(input logic [1:0] sel,
                                                       input logic [`REG_AW-1:0] src);
        if (sel == `FWD_MEM)
            return mRes[2];
        if (sel == `FWD_WB)
            return mRes[3];
        return mRf[src];
    endfunction

    task automatic driveRandom();
        logic [31:0] r;
        logic [31:0] bias;
        instrWord_t  w;
        r    = $random(seed);
        bias = $random(seed);
        w    = $random(seed);
        iCacheStall  <= (r[2:0] == 3'd0); // each stall about one cycle in eight
        dCacheStall  <= (r[5:3] == 3'd0);
        divStall     <= (r[8:6] == 3'd0);
        predFail     <= (r[11:9] == 3'd0);
        jumpConflict <= (r[14:12] == 3'd0);
        exception    <= (r[19:15] == 5'd0); // rarer
        issueValid   <= (r[21:20] != 2'd0);
        if (bias[0])
            w.r.op = 6'd0;
        // crowd into r0..r3 so back-to-back dependencies show up often
        if (bias[1])
            w.r.rs = {3'd0, bias[5:4]};
        if (bias[2])
            w.r.rt = {3'd0, bias[7:6]};
        if (bias[3])
            w.r.rd = {3'd0, bias[9:8]};
        issueInstr  <= w;
        issueResult <= $random(seed);
    endtask

    task automatic compareOutputs(input logic [7:0] c);
        logic [1:0] selA;
        logic [1:0] selB;
        logic       commit;
        selA   = bypassSel(mRs[1]);
        selB   = bypassSel(mRt[1]);
        commit = mValid[3] & mWe[3] & ~c[3]; // W lets go unless held
        checkCtl("hold/flush vector",
                 {holdF, holdD, holdE, holdM, holdW, flushD, flushE, flushM}, c);
        checkBit("stallWindow", stallWindow, c[6] | mLongQ); // c[6] is the long stall
        checkFwd("fwdA", fwdA, selA);
        checkFwd("fwdB", fwdB, selB);
        checkWord("operandA", operandA, operandValue(selA, mRs[1]));
        checkWord("operandB", operandB, operandValue(selB, mRt[1]));
        checkBit("commitValid", commitValid, commit);
        if (commit) begin
            checkReg("commitDest", commitDest, mDest[3]);
            checkWord("commitData", commitData, mRes[3]);
        end
    endtask

    // one rising edge, oldest stage first so each reads its old neighbour
    task automatic stepModel(input logic [7:0] c);
        if (mValid[3] && mWe[3] && !c[3] && mDest[3] != '0)
            mRf[mDest[3]] = mRes[3];
        if (!c[3]) begin
            mValid[3] = mValid[2] & ~c[4]; // held M hands on a bubble
            mDest[3]  = mDest[2];
            mWe[3]    = mWe[2];
            mRes[3]   = mRes[2];
        end
        if (c[0])
            mValid[2] = 1'b0;
        else if (!c[4])
            mValid[2] = mValid[1] & ~c[5];
        if (!c[4]) begin
            mDest[2] = mDest[1];
            mWe[2]   = mWe[1];
            mRes[2]  = mRes[1];
        end
        if (c[1])
            mValid[1] = 1'b0;
        else if (!c[5])
            mValid[1] = mValid[0] & ~c[6];
        if (!c[5]) begin
            mRs[1]   = mRs[0];
            mRt[1]   = mRt[0];
            mDest[1] = mDest[0];
            mWe[1]   = mWe[0];
            mRes[1]  = mRes[0];
        end
        if (c[2])
            mValid[0] = 1'b0;
        else if (!c[6])
            mValid[0] = issueValid; // issue lost while D is held
        if (!c[6]) begin
            mRs[0]   = issueInstr.r.rs;
            mRt[0]   = issueInstr.r.rt;
            mDest[0] = (issueInstr.r.op == 6'd0) ? issueInstr.r.rd : issueInstr.i.rt;
            mWe[0]   = writesReg(issueInstr.i.op);
            mRes[0]  = issueResult;
        end
        mLongQ = c[6];
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        issueValid   = 1'b0;
        issueInstr   = '0;
        issueResult  = '0;
        iCacheStall  = 1'b0;
        dCacheStall  = 1'b0;
        divStall     = 1'b0;
        predFail     = 1'b0;
        jumpConflict = 1'b0;
        exception    = 1'b0;
        seed         = 32'hb90b30bd;
        mLongQ       = 1'b0;
        // quiet reset cycles leave every payload at zero
        for (int i = 0; i < 4; i++) begin
            mValid[i] = 1'b0;
            mDest[i]  = '0;
            mWe[i]    = 1'b0;
            mRes[i]   = '0;
        end
        for (int i = 0; i < 2; i++) begin
            mRs[i] = '0;
            mRt[i] = '0;
        end
        for (int i = 0; i < 32; i++)
            mRf[i] = '0;
        repeat (NRESET) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkCtl("hold/flush vector after reset",
                 {holdF, holdD, holdE, holdM, holdW, flushD, flushE, flushM}, 8'h00);
        checkBit("commitValid after reset", commitValid, 1'b0);
        for (int n = 0; n < NCYCLES; n++) begin
            @(posedge clk);
            driveRandom();
            @(negedge clk); // outputs settled, inputs steady until the next edge
            ctl = ctlRule();
            compareOutputs(ctl);
            stepModel(ctl);
        end
        @(posedge clk); // last modelled edge
        @(negedge clk);
        for (int r = 0; r < 32; r++)
            checkWord($sformatf("regFile[%0d]", r), uut.tracker.regFile[r], mRf[r]);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/hazardPkg.sv
hw/stageBus.sv
hw/hazardCtl.sv
hw/forwardUnit.sv
hw/stallFlushUnit.sv
hw/pipeTrack.sv
hw/hazardTop.sv
test/hazard_properties.sv
test/tbHazard.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbHazard
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
